// ==== Bender.yml ====
package:
  name: uart_periph

sources:
  # Packages first, then the RTL bottom up
  - hdl/uart_bus_pkg.sv
  - hdl/uart_reg_pkg.sv
  - hdl/uart_regs.sv
  - hdl/uart_tx_fifo.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_periph.sv

  - target: test
    files:
      - sim/tb_uart_periph.sv

// ==== flist.f ====
hdl/uart_bus_pkg.sv
hdl/uart_reg_pkg.sv
hdl/uart_regs.sv
hdl/uart_tx_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_periph.sv
sim/tb_uart_periph.sv

// ==== hdl/uart_bus_pkg.sv ====
/*
 * Data-bus request and response structs shared with the interconnect
 */
`default_nettype none

package uart_bus_pkg;

    // ------------------------------------------------------------
    // Request from the interconnect
    // ------------------------------------------------------------

    // Held steady with cyc high until the peripheral acknowledges
    typedef struct packed {
        logic        cyc;
        logic        w_en;
        logic [31:0] addr;
        logic [31:0] w_data;
    } dbus_req_s;

    // ------------------------------------------------------------
    // Response to the interconnect
    // ------------------------------------------------------------

    // ack is a single-cycle pulse, r_data valid in that cycle
    typedef struct packed {
        logic        ack;
        logic [31:0] r_data;
    } dbus_rsp_s;

endpackage

`default_nettype wire

// ==== hdl/uart_periph.sv ====
/*
 * UART peripheral top: register block, transmit FIFO,
 * transmitter and receiver
 */
`default_nettype none

module uart_periph #(
    parameter int FIFO_DEPTH = 4,
    parameter int BAUD_RESET = 8
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire uart_bus_pkg::dbus_req_s dbus_req_i,
    input  wire logic                    sel_i,
    output uart_bus_pkg::dbus_rsp_s      dbus_rsp_o,
    output logic                         irq_o,
    input  wire logic                    rxd_i,
    output logic                         txd_o
);

    logic                       push;
    logic [7:0]                 push_data;
    logic                       fifo_full;
    logic                       fifo_empty;
    logic [7:0]                 fifo_head;
    logic                       tx_pop;
    logic                       tx_busy;
    logic [7:0]                 baud_div;
    logic                       two_stop;
    uart_reg_pkg::uart_rx_evt_s rx_evt;

    // Producer: bus registers
    uart_regs #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .BAUD_RESET (BAUD_RESET)
    ) u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .dbus_req_i   (dbus_req_i),
        .sel_i        (sel_i),
        .dbus_rsp_o   (dbus_rsp_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .tx_busy_i    (tx_busy),
        .rx_evt_i     (rx_evt),
        .baud_div_o   (baud_div),
        .two_stop_o   (two_stop),
        .irq_o        (irq_o)
    );

    uart_tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .DATA_W     (8)
    ) u_tx_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (tx_pop),
        .head_o      (fifo_head),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    // Consumer: serial transmitter
    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty_i    (fifo_empty),
        .head_i     (fifo_head),
        .baud_div_i (baud_div),
        .two_stop_i (two_stop),
        .pop_o      (tx_pop),
        .busy_o     (tx_busy),
        .txd_o      (txd_o)
    );

    uart_rx u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rxd_i      (rxd_i),
        .baud_div_i (baud_div),
        .evt_o      (rx_evt)
    );

endmodule

`default_nettype wire

// ==== hdl/uart_reg_pkg.sv ====
/*
 * UART register map, line control and status bit positions,
 * and the receiver report bundle
 */
`default_nettype none

package uart_reg_pkg;

    // Register index, taken from address bits 4 to 2
    typedef enum logic [2:0] {
        DATA    = 3'd0,
        BAUD    = 3'd1,
        LCTRL   = 3'd2,
        LSTATUS = 3'd3,
        IE      = 3'd4,
        SCRATCH = 3'd7
    } uart_reg_e;

    // Line control bits
    localparam int unsigned LCTRL_TWO_STOP = 0;

    // Line status bits, IE uses the same positions
    localparam int unsigned ST_RX_READY    = 0;
    localparam int unsigned ST_FRAME_ERR   = 1;
    localparam int unsigned ST_TX_NOT_FULL = 5;
    localparam int unsigned ST_TX_IDLE     = 6;

    // Receiver report, valid and frame_err are single-cycle strobes
    typedef struct packed {
        logic       valid;
        logic       frame_err;
        logic [7:0] data;
    } uart_rx_evt_s;

endpackage

`default_nettype wire

// ==== hdl/uart_regs.sv ====
/*
 * UART register block with bus decode and ack, register file,
 * sticky line status, interrupt and transmit FIFO push
 */
`default_nettype none

module uart_regs #(
    parameter int FIFO_DEPTH = 4,
    parameter int BAUD_RESET = 8
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire uart_bus_pkg::dbus_req_s      dbus_req_i,
    input  wire logic                         sel_i,
    output uart_bus_pkg::dbus_rsp_s           dbus_rsp_o,

    output logic                              push_o,
    output logic [7:0]                        push_data_o,
    input  wire logic                         fifo_full_i,
    input  wire logic                         fifo_empty_i,
    input  wire logic                         tx_busy_i,
    input  wire uart_reg_pkg::uart_rx_evt_s   rx_evt_i,

    output logic [7:0]                        baud_div_o,
    output logic                              two_stop_o,
    output logic                              irq_o
);

    uart_reg_pkg::uart_reg_e reg_addr;
    logic                    accept;
    logic                    wr_stb;
    logic                    rd_stb;
    logic [7:0]              w_byte;
    logic [7:0]              rd_byte;
    logic [7:0]              status;

    logic                    ack_q;
    logic [31:0]             r_data_q;
    logic [7:0]              baud_q;
    logic [7:0]              lctrl_q;
    logic [7:0]              ie_q;
    logic [7:0]              scratch_q;
    logic [7:0]              rx_data_q;
    logic                    rx_ready_q;
    logic                    frame_err_q;
    logic                    irq_q;

    // ------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------

    // The ack cycle blocks a second accept of a held request
    assign reg_addr = uart_reg_pkg::uart_reg_e'(dbus_req_i.addr[4:2]);
    assign accept   = dbus_req_i.cyc & sel_i & ~ack_q;
    assign wr_stb   = accept & dbus_req_i.w_en;
    assign rd_stb   = accept & ~dbus_req_i.w_en;
    assign w_byte   = dbus_req_i.w_data[7:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stb) begin
            r_data_q <= {24'd0, rd_byte};
        end
    end

    assign dbus_rsp_o = '{ack: ack_q, r_data: r_data_q};

    // ------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------

    always_comb begin
        status                                 = '0;
        status[uart_reg_pkg::ST_RX_READY]    = rx_ready_q;
        status[uart_reg_pkg::ST_FRAME_ERR]   = frame_err_q;
        status[uart_reg_pkg::ST_TX_NOT_FULL] = ~fifo_full_i;
        status[uart_reg_pkg::ST_TX_IDLE]     = fifo_empty_i & ~tx_busy_i;
    end

    always_comb begin
        case (reg_addr)
            uart_reg_pkg::DATA:    rd_byte = rx_data_q;
            uart_reg_pkg::BAUD:    rd_byte = baud_q;
            uart_reg_pkg::LCTRL:   rd_byte = lctrl_q;
            uart_reg_pkg::LSTATUS: rd_byte = status;
            uart_reg_pkg::IE:      rd_byte = ie_q;
            uart_reg_pkg::SCRATCH: rd_byte = scratch_q;
            default:               rd_byte = '0;
        endcase
    end

    // LSTATUS and unused addresses ignore writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_q    <= 8'(BAUD_RESET);
            lctrl_q   <= '0;
            ie_q      <= '0;
            scratch_q <= '0;
        end else if (wr_stb) begin
            case (reg_addr)
                uart_reg_pkg::BAUD:    baud_q    <= w_byte;
                uart_reg_pkg::LCTRL:   lctrl_q   <= w_byte;
                uart_reg_pkg::IE:      ie_q      <= w_byte;
                uart_reg_pkg::SCRATCH: scratch_q <= w_byte;
                default: ;
            endcase
        end
    end

    // Data writes go straight to the FIFO and are lost when it is full
    assign push_o      = wr_stb & (reg_addr == uart_reg_pkg::DATA) & ~fifo_full_i;
    assign push_data_o = w_byte;
    assign baud_div_o  = baud_q;
    assign two_stop_o  = lctrl_q[uart_reg_pkg::LCTRL_TWO_STOP];

    // ------------------------------------------------------------
    // Sticky status and interrupt
    // ------------------------------------------------------------

    // New receiver events win over a clearing read in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_ready_q  <= 1'b0;
            frame_err_q <= 1'b0;
            rx_data_q   <= '0;
            irq_q       <= 1'b0;
        end else begin
            if (rx_evt_i.valid) begin
                rx_ready_q <= 1'b1;
                rx_data_q  <= rx_evt_i.data;
            end else if (rd_stb && reg_addr == uart_reg_pkg::DATA) begin
                rx_ready_q <= 1'b0;
            end
            if (rx_evt_i.frame_err) begin
                frame_err_q <= 1'b1;
            end else if (rd_stb && reg_addr == uart_reg_pkg::LSTATUS) begin
                frame_err_q <= 1'b0;
            end
            irq_q <= |(status & ie_q);
        end
    end

    assign irq_o = irq_q;

    // A pushed byte is waiting in the FIFO one cycle later
    assert property (@(posedge clk) disable iff (!rst_n) push_o |=> !fifo_empty_i);

    // Starting from empty, full needs at least FIFO_DEPTH pushes
    assert property (@(posedge clk) disable iff (!rst_n)
        fifo_empty_i |-> !fifo_full_i [*FIFO_DEPTH]);

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
/*
 * Serial receiver with input synchronizer, mid-bit sampling,
 * glitch rejection on the start bit and stop bit check
 */
`default_nettype none

module uart_rx (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 rxd_i,
    input  wire logic [7:0]           baud_div_i,
    output uart_reg_pkg::uart_rx_evt_s evt_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } rx_state_e;

    rx_state_e  state_q;
    logic [2:0] rxd_pipe_q;
    logic [7:0] baud_cnt_q;
    logic [2:0] bit_idx_q;
    logic [7:0] shift_q;
    logic       valid_q;
    logic       ferr_q;
    logic       rxd_s;
    logic       fall;
    logic       mid_start;
    logic       bit_end;

    // Bits 0 and 1 synchronize and bit 2 is kept for edge detection
    assign rxd_s = rxd_pipe_q[1];
    assign fall  = rxd_pipe_q[2] & ~rxd_pipe_q[1];

    // The minus one makes up for the counter starting a cycle after the edge
    assign mid_start = (baud_cnt_q == {1'b0, baud_div_i[7:1]} - 8'd1);
    assign bit_end   = (baud_cnt_q == baud_div_i - 8'd1);

    // ------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_pipe_q <= '1;
            state_q    <= S_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            valid_q    <= 1'b0;
            ferr_q     <= 1'b0;
        end else begin
            rxd_pipe_q <= {rxd_pipe_q[1:0], rxd_i};
            baud_cnt_q <= baud_cnt_q + 8'd1;
            valid_q    <= 1'b0;
            ferr_q     <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (fall) begin
                        state_q    <= S_START;
                        baud_cnt_q <= '0;
                    end
                end
                S_START: begin
                    // A line that is high again by mid start bit was a glitch
                    if (mid_start) begin
                        state_q    <= rxd_s ? S_IDLE : S_DATA;
                        baud_cnt_q <= '0;
                        bit_idx_q  <= '0;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= S_STOP;
                        end
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        state_q <= S_IDLE;
                        valid_q <= rxd_s;
                        ferr_q  <= ~rxd_s;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // LSB arrives first and is shifted in from the top
    always_ff @(posedge clk) begin
        if (state_q == S_DATA && bit_end) begin
            shift_q <= {rxd_s, shift_q[7:1]};
        end
    end

    assign evt_o = '{valid: valid_q, frame_err: ferr_q, data: shift_q};

    // The bit timer stays inside one bit time while a frame is in progress
    assert property (@(posedge clk) disable iff (!rst_n)
        (state_q != S_IDLE) |-> (baud_cnt_q < baud_div_i));

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
/*
 * Serial transmitter: pops the FIFO, sends start, 8 data bits LSB first
 * and one or two stop bits
 */
`default_nettype none

module uart_tx (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       empty_i,
    input  wire logic [7:0] head_i,
    input  wire logic [7:0] baud_div_i,
    input  wire logic       two_stop_i,
    output logic            pop_o,
    output logic            busy_o,
    output logic            txd_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP1,
        S_STOP2
    } tx_state_e;

    tx_state_e  state_q;
    logic [7:0] baud_cnt_q;
    logic [2:0] bit_idx_q;
    logic [7:0] shift_q;
    logic       txd_q;
    logic       bit_end;

    assign bit_end = (baud_cnt_q == baud_div_i - 8'd1);
    assign pop_o   = (state_q == S_IDLE) & ~empty_i;
    assign busy_o  = (state_q != S_IDLE);
    assign txd_o   = txd_q;

    // Bit timer, restarted by a pop and at every bit boundary
    always_ff @(posedge clk) begin
        if (!rst_n || pop_o || bit_end) begin
            baud_cnt_q <= '0;
        end else begin
            baud_cnt_q <= baud_cnt_q + 8'd1;
        end
    end

    // Shift register, bit 0 is always the next bit to go out
    always_ff @(posedge clk) begin
        if (pop_o) begin
            shift_q <= head_i;
        end else if (bit_end && (state_q == S_START || state_q == S_DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    // ------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            bit_idx_q <= '0;
            txd_q     <= 1'b1;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (pop_o) begin
                        state_q <= S_START;
                        txd_q   <= 1'b0;
                    end
                end
                S_START: begin
                    if (bit_end) begin
                        state_q   <= S_DATA;
                        bit_idx_q <= '0;
                        txd_q     <= shift_q[0];
                    end
                end
                S_DATA: begin
                    if (bit_end && bit_idx_q == 3'd7) begin
                        state_q <= S_STOP1;
                        txd_q   <= 1'b1;
                    end else if (bit_end) begin
                        bit_idx_q <= bit_idx_q + 3'd1;
                        txd_q     <= shift_q[0];
                    end
                end
                S_STOP1: begin
                    if (bit_end) begin
                        state_q <= two_stop_i ? S_STOP2 : S_IDLE;
                    end
                end
                S_STOP2: begin
                    if (bit_end) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_tx_fifo.sv ====
/*
 * Synchronous circular FIFO for transmit bytes, head readable without pop
 */
`default_nettype none

module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 4,
    parameter int DATA_W     = 8
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              push_i,
    input  wire logic [DATA_W-1:0] push_data_i,
    input  wire logic              pop_i,
    output logic [DATA_W-1:0]      head_o,
    output logic                   full_o,
    output logic                   empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_push;
    logic              do_pop;

    // Pointers wrap at FIFO_DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // The transmitter only pops when it sees a byte waiting
    assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== sim/tb_uart_periph.sv ====
/*
 * Self-checking testbench for the UART peripheral with bus tasks,
 * serial frame driver, txd monitor and protocol assertions
 */
`default_nettype none

module tb_uart_periph;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH = 4;
    localparam int BAUD_RESET = 8;

    // Register addresses carry the index in bits 4 to 2
    localparam logic [31:0] A_DATA    = 32'h00;
    localparam logic [31:0] A_BAUD    = 32'h04;
    localparam logic [31:0] A_LCTRL   = 32'h08;
    localparam logic [31:0] A_LSTATUS = 32'h0C;
    localparam logic [31:0] A_IE      = 32'h10;
    localparam logic [31:0] A_UNUSED  = 32'h14;
    localparam logic [31:0] A_SCRATCH = 32'h1C;

    localparam int ST_RX_READY    = 0;
    localparam int ST_FRAME_ERR   = 1;
    localparam int ST_TX_NOT_FULL = 5;
    localparam int ST_TX_IDLE     = 6;

    // Watchdog limit allows every frame at the slowest divisor with two stop bits
    localparam int MAX_BAUD       = 10;
    localparam int N_FRAMES       = 16;
    localparam int FRAME_CLKS     = 11 * MAX_BAUD;
    localparam int TIMEOUT_CYCLES = N_FRAMES * FRAME_CLKS + 3000;

    logic                    clk;
    logic                    rst_n;
    uart_bus_pkg::dbus_req_s dbus_req;
    logic                    sel;
    uart_bus_pkg::dbus_rsp_s dbus_rsp;
    logic                    irq;
    logic                    rxd;
    logic                    txd;

    int         errors;
    int         tests_run;
    int         tests_failed;
    int         cycle_cnt;
    int         bit_clks;
    bit         mon_two_stop;
    logic [7:0] tx_expect[$];
    logic [7:0] tx_seen[$];

    uart_periph #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .BAUD_RESET (BAUD_RESET)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .dbus_req_i (dbus_req),
        .sel_i      (sel),
        .dbus_rsp_o (dbus_rsp),
        .irq_o      (irq),
        .rxd_i      (rxd),
        .txd_o      (txd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    endtask

    // Starts just after a falling edge and returns on the falling edge that sees ack
    task automatic bus_access(input logic w_en, input logic [31:0] addr,
                              input logic [31:0] w_data, output logic [31:0] r_data);
        dbus_req = '{cyc: 1'b1, w_en: w_en, addr: addr, w_data: w_data};
        sel      = 1'b1;
        do begin
            @(negedge clk);
        end while (!dbus_rsp.ack);
        r_data   = dbus_rsp.r_data;
        dbus_req = '0;
        sel      = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'd0, data);
    endtask

    task automatic wait_tx_idle();
        logic [31:0] st;
        do begin
            bus_read(A_LSTATUS, st);
        end while (!st[ST_TX_IDLE]);
    endtask

    task automatic wait_irq();
        while (!irq) begin
            @(negedge clk);
        end
    endtask

    // Start bit, 8 data bits LSB first, chosen stop level, then idle
    task automatic send_rx_frame(input logic [7:0] data, input logic stop_bit);
        rxd = 1'b0;
        repeat (bit_clks) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];
            repeat (bit_clks) @(negedge clk);
        end
        rxd = stop_bit;
        repeat (bit_clks) @(negedge clk);
        rxd = 1'b1;
        repeat (bit_clks) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("%s: %s", name, (errors == errs_before) ? "pass" : "fail");
    endtask

    task automatic check_queues();
        logic [7:0] exp;
        logic [7:0] got;
        while (tx_expect.size() > 0 && tx_seen.size() > 0) begin
            exp = tx_expect.pop_front();
            got = tx_seen.pop_front();
            assert (got == exp) else report_mismatch("txd byte", exp, got);
        end
        assert (tx_expect.size() == 0) else
            report_mismatch("tx_expect left", 0, tx_expect.size());
        assert (tx_seen.size() == 0) else report_mismatch("tx_seen left", 0, tx_seen.size());
        tx_expect.delete();
        tx_seen.delete();
    endtask

    // ------------------------------------------------------------
    // txd monitor sampling at bit middles on falling edges
    // ------------------------------------------------------------

    initial begin
        logic [7:0] b;
        forever begin
            @(negedge clk);
            if (rst_n && txd === 1'b0) begin
                repeat (bit_clks / 2 - 1) @(negedge clk);
                assert (txd == 1'b0) else report_mismatch("txd start bit", 0, txd);
                for (int i = 0; i < 8; i++) begin
                    repeat (bit_clks) @(negedge clk);
                    b[i] = txd;
                end
                repeat (bit_clks) @(negedge clk);
                assert (txd == 1'b1) else report_mismatch("txd stop bit", 1, txd);
                if (mon_two_stop) begin
                    // Line must stay high through the middle of the second stop bit
                    repeat (bit_clks) begin
                        @(negedge clk);
                        assert (txd == 1'b1) else report_mismatch("txd stop2 bit", 1, txd);
                    end
                end
                tx_seen.push_back(b);
            end
        end
    end

    // ------------------------------------------------------------
    // Protocol assertions
    // ------------------------------------------------------------

    assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_req.cyc && sel && !dbus_rsp.ack) |=> dbus_rsp.ack)
        else report_mismatch("dbus_rsp.ack after accept", 1, 0);

    assert property (@(posedge clk) disable iff (!rst_n) dbus_rsp.ack |=> !dbus_rsp.ack)
        else report_mismatch("dbus_rsp.ack second cycle", 0, 1);

    assert property (@(posedge clk) disable iff (!rst_n)
        uut.u_regs.status[ST_TX_IDLE] |-> txd)
        else report_mismatch("txd while TX_IDLE", 1, 0);

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        logic [31:0] rd;
        logic [31:0] st;
        logic [31:0] w;
        logic [7:0]  b;
        int          eb;
        int          dropped;
        int          decoded;
        bit          saw_full;

        void'($urandom(32'h5220));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        bit_clks     = BAUD_RESET;
        mon_two_stop = 1'b0;
        rst_n        = 1'b0;
        dbus_req     = '0;
        sel          = 1'b0;
        rxd          = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset values
        eb = errors;
        bus_read(A_BAUD, rd);
        assert (rd == BAUD_RESET) else report_mismatch("BAUD", BAUD_RESET, rd);
        bus_read(A_SCRATCH, rd);
        assert (rd == 0) else report_mismatch("SCRATCH", 0, rd);
        bus_read(A_IE, rd);
        assert (rd == 0) else report_mismatch("IE", 0, rd);
        bus_read(A_LCTRL, rd);
        assert (rd == 0) else report_mismatch("LCTRL", 0, rd);
        bus_read(A_LSTATUS, rd);
        w = (32'd1 << ST_TX_NOT_FULL) | (32'd1 << ST_TX_IDLE);
        assert (rd == w) else report_mismatch("LSTATUS", w, rd);
        assert (irq == 1'b0) else report_mismatch("irq", 0, irq);
        assert (txd == 1'b1) else report_mismatch("txd", 1, txd);
        end_test("reset state", eb);

        // Register read back with 8-bit masking and read-only status
        eb = errors;
        w = $urandom;
        bus_write(A_SCRATCH, w);
        bus_read(A_SCRATCH, rd);
        assert (rd == (w & 32'hFF)) else report_mismatch("SCRATCH", w & 32'hFF, rd);
        bus_write(A_IE, 32'h3C3C_3CA5);
        bus_read(A_IE, rd);
        assert (rd == 32'hA5) else report_mismatch("IE", 32'hA5, rd);
        bus_write(A_LCTRL, 32'h5A5A_5A5A);
        bus_read(A_LCTRL, rd);
        assert (rd == 32'h5A) else report_mismatch("LCTRL", 32'h5A, rd);
        bus_write(A_BAUD, 32'hABCD_EF0A);
        bus_read(A_BAUD, rd);
        assert (rd == 32'h0A) else report_mismatch("BAUD", 32'h0A, rd);
        bit_clks = 10;
        bus_read(A_LSTATUS, st);
        bus_write(A_LSTATUS, ~st);
        bus_read(A_LSTATUS, rd);
        assert (rd == st) else report_mismatch("LSTATUS after write", st, rd);
        bus_write(A_UNUSED, 32'hFFFF_FFFF);
        bus_read(A_UNUSED, rd);
        assert (rd == 0) else report_mismatch("unused register", 0, rd);
        bus_write(A_IE, 32'd0);
        bus_write(A_LCTRL, 32'd0);
        end_test("register read back", eb);

        // Transmit with one stop bit, then with two
        eb = errors;
        for (int phase = 0; phase < 2; phase++) begin
            if (phase == 1) begin
                mon_two_stop = 1'b1;
                bus_write(A_LCTRL, 32'd1);
            end
            for (int i = 0; i < 3; i++) begin
                do begin
                    bus_read(A_LSTATUS, st);
                end while (!st[ST_TX_NOT_FULL]);
                b = 8'($urandom);
                bus_write(A_DATA, {24'd0, b});
                tx_expect.push_back(b);
            end
            while (tx_seen.size() < tx_expect.size()) begin
                @(negedge clk);
            end
            wait_tx_idle();
            check_queues();
        end
        bus_write(A_LCTRL, 32'd0);
        mon_two_stop = 1'b0;
        end_test("transmit", eb);

        // FIFO fill where writes after a full status may be dropped
        eb = errors;
        dropped  = 0;
        saw_full = 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            bus_read(A_LSTATUS, st);
            b = 8'($urandom);
            bus_write(A_DATA, {24'd0, b});
            if (st[ST_TX_NOT_FULL]) begin
                tx_expect.push_back(b);
            end else begin
                saw_full = 1'b1;
                dropped++;
            end
        end
        assert (saw_full) else begin
            errors++;
            $display("CHECK FAILED at %0t: TX_NOT_FULL never read low", $time);
        end
        while (tx_seen.size() < tx_expect.size()) begin
            @(negedge clk);
        end
        wait_tx_idle();
        decoded = tx_seen.size();
        assert (FIFO_DEPTH + 3 == decoded + dropped) else
            report_mismatch("decoded plus dropped", FIFO_DEPTH + 3, decoded + dropped);
        check_queues();
        end_test("fifo fill", eb);

        // Receive with RX_READY interrupt
        eb = errors;
        bus_write(A_IE, 32'd1 << ST_RX_READY);
        b = 8'($urandom);
        send_rx_frame(b, 1'b1);
        wait_irq();
        bus_read(A_LSTATUS, st);
        assert (st[ST_RX_READY]) else report_mismatch("RX_READY", 1, st[ST_RX_READY]);
        bus_read(A_DATA, rd);
        assert (rd == {24'd0, b}) else report_mismatch("DATA", b, rd);
        bus_read(A_LSTATUS, st);
        assert (!st[ST_RX_READY]) else report_mismatch("RX_READY", 0, st[ST_RX_READY]);
        assert (irq == 1'b0) else report_mismatch("irq", 0, irq);
        end_test("receive", eb);

        // Framing error with FRAME_ERR interrupt
        eb = errors;
        bus_write(A_IE, 32'd1 << ST_FRAME_ERR);
        send_rx_frame(8'($urandom), 1'b0);
        wait_irq();
        bus_read(A_LSTATUS, st);
        assert (st[ST_FRAME_ERR]) else report_mismatch("FRAME_ERR", 1, st[ST_FRAME_ERR]);
        assert (!st[ST_RX_READY]) else report_mismatch("RX_READY", 0, st[ST_RX_READY]);
        bus_read(A_LSTATUS, st);
        assert (!st[ST_FRAME_ERR]) else report_mismatch("FRAME_ERR", 0, st[ST_FRAME_ERR]);
        assert (irq == 1'b0) else report_mismatch("irq", 0, irq);
        end_test("framing error", eb);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
